//--- rtl/qspi_phy_pkg.sv
// Shared widths, timing constants and encodings of the quad-SPI physical layer.
// Every RTL block and the testbench import this package.

`default_nettype none

package qspi_phy_pkg;

  // ==============================
  // Widths
  // ==============================

  localparam int unsigned DIV_W  = 12;  // Clock divider and tick counter.
  localparam int unsigned CNT_W  = 8;   // Serial clock periods per operation.
  localparam int unsigned DATA_W = 8;   // One byte per transfer.
  localparam int unsigned DQ_W   = 4;   // Data lanes on the pads.

  // Cycles from a sample strobe to the capture into the buffer.
  // The same delay applies from the last strobe to done, so the byte and
  // its valid flag appear together.
  localparam int unsigned SAMPLE_DELAY = 3;

  // ==============================
  // Encodings
  // ==============================

  // Lane format of a transfer.
  typedef enum logic [1:0] {
    PROTO_SINGLE = 2'd0,  // Out on lane 0, in on lane 1.
    PROTO_DUAL   = 2'd1,
    PROTO_QUAD   = 2'd2
  } proto_e;

  // Operation kind.
  typedef enum logic {
    FN_TRANSFER = 1'b0,  // Shift a byte out and in.
    FN_TIMING   = 1'b1   // Hold the bus for a number of clock periods.
  } op_fn_e;

endpackage

`default_nettype wire

//--- rtl/qspi_sck_gen.sv
// Serial clock scheduler of the quad-SPI physical layer.
// A tick counter divides the system clock into half periods, and a beat
// counter loaded from the operation counts whole periods. Each half period
// is marked as a sample or a setup beat for the shift buffer.

`timescale 1ns/1ps
`default_nettype none

module qspi_sck_gen
  import qspi_phy_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  input  wire              op_fire_i,
  input  var  op_fn_e      op_fn_i,
  input  wire              op_stb_i,
  input  wire [CNT_W-1:0]  op_cnt_i,
  input  wire [DIV_W-1:0]  sck_div_i,
  input  wire              sck_pol_i,
  input  wire              sck_pha_i,
  output logic             sck_o,
  output logic             setup_o,
  output logic             sample_o,
  output logic             last_o,
  output logic             stop_o
);

  logic [DIV_W-1:0] div_q;
  logic             pol_q;
  logic             pha_q;
  op_fn_e           fn_q;
  logic [DIV_W-1:0] tcnt_q;
  logic [CNT_W-1:0] scnt_q;
  logic             cref_q;   // Reference phase, high before the sample half.
  logic             beat;
  logic             run;
  logic             xfr;
  logic             cinv;
  logic             end_beat;

  assign stop_o = (scnt_q == '0);
  assign beat   = (tcnt_q == '0);
  assign run    = !stop_o && beat;
  assign xfr    = (fn_q == FN_TRANSFER);
  assign cinv   = pha_q ^ pol_q;

  // The setup half of the final period closes the operation.
  assign end_beat = run && !cref_q && (scnt_q == CNT_W'(1));

  assign sample_o = run && xfr && cref_q;
  assign last_o   = sample_o && (scnt_q == CNT_W'(1));
  // A transfer drives its first lane bits in the accepting cycle.
  assign setup_o  = (op_fire_i && (op_fn_i == FN_TRANSFER)) ||
                    (run && xfr && !cref_q && !end_beat);

  // ==============================
  // Settings
  // ==============================

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_q <= '0;
      pol_q <= 1'b0;
      pha_q <= 1'b0;
      fn_q  <= FN_TIMING;
    end else if (op_fire_i) begin
      fn_q <= op_fn_i;
      if ((op_fn_i == FN_TIMING) && op_stb_i) begin
        div_q <= sck_div_i;
        pol_q <= sck_pol_i;
        pha_q <= sck_pha_i;
      end
    end
  end

  // ==============================
  // Counters and serial clock
  // ==============================

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tcnt_q <= '0;
      scnt_q <= '0;
      cref_q <= 1'b1;
    end else begin
      if (stop_o || beat) begin
        tcnt_q <= div_q;  // Half period is div plus one cycles.
      end else begin
        tcnt_q <= tcnt_q - 1'b1;
      end
      if (op_fire_i) begin
        scnt_q <= op_cnt_i;
      end else if (run && !cref_q) begin
        scnt_q <= scnt_q - 1'b1;
      end
      if (run) begin
        cref_q <= !cref_q;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sck_o <= 1'b0;
    end else if (op_fire_i) begin
      if ((op_fn_i == FN_TRANSFER) && (op_cnt_i != '0)) begin
        sck_o <= cinv;  // Phase 1 moves the clock off idle right away.
      end else if ((op_fn_i == FN_TIMING) && op_stb_i) begin
        sck_o <= sck_pol_i;
      end
    end else if (end_beat) begin
      sck_o <= pol_q;
    end else if (run && xfr) begin
      sck_o <= cref_q ^ cinv;
    end
  end

  // Between operations the serial clock rests at its idle polarity.
  a_sck_idle: assert property (@(posedge clock) disable iff (reset)
    stop_o |-> (sck_o == pol_q))
    else $error("sck_o left its idle level while the scheduler was idle");

endmodule

`default_nettype wire

//--- rtl/qspi_shift_buffer.sv
// Shift datapath of the quad-SPI physical layer.
// Holds the byte being sent and received, the lane output register and the
// format settings. Received lanes are captured after the pad delay and the
// byte is turned back into the requested bit order for the caller.

`timescale 1ns/1ps
`default_nettype none

module qspi_shift_buffer
  import qspi_phy_pkg::*;
(
  input  wire               clock,
  input  wire               reset,
  input  wire               op_fire_i,
  input  var  op_fn_e       op_fn_i,
  input  wire               op_stb_i,
  input  wire [DATA_W-1:0]  op_data_i,
  input  var  proto_e       fmt_proto_i,
  input  wire               fmt_endian_i,  // High for LSB-first.
  input  wire               setup_i,
  input  wire               sample_i,
  input  wire               stop_i,
  input  wire [DQ_W-1:0]    dq_i,
  output proto_e            proto_o,
  output logic [DQ_W-1:0]   dq_o,
  output logic [DATA_W-1:0] rx_data_o
);

  proto_e                  proto_q;
  proto_e                  proto_eff;
  logic                    endian_q;
  logic                    endian_eff;
  logic                    load_fmt;
  logic                    fire_xfr;
  logic [DATA_W-1:0]       tx_byte;
  logic [DQ_W-1:0]         tx_top;
  logic [DATA_W-1:0]       buf_q;
  logic [DATA_W-1:0]       buf_next;
  logic [DQ_W-1:0]         txd_q;
  logic [DQ_W-1:0]         txd_next;
  logic                    setup_d_q;
  logic [SAMPLE_DELAY-1:0] sample_pipe_q;
  logic                    sample_d;
  logic                    shift;

  function automatic logic [DATA_W-1:0] bit_reverse(input logic [DATA_W-1:0] value);
    logic [DATA_W-1:0] result;
    for (int i = 0; i < DATA_W; i++) begin
      result[i] = value[DATA_W-1-i];
    end
    return result;
  endfunction

  assign load_fmt   = op_fire_i && op_stb_i;
  assign fire_xfr   = op_fire_i && (op_fn_i == FN_TRANSFER);
  assign proto_eff  = load_fmt ? fmt_proto_i : proto_q;
  assign endian_eff = load_fmt ? fmt_endian_i : endian_q;

  // The buffer always shifts from the top, so LSB-first bytes enter reversed.
  assign tx_byte = endian_eff ? bit_reverse(op_data_i) : op_data_i;
  assign tx_top  = fire_xfr ? tx_byte[DATA_W-1 -: DQ_W] : buf_q[DATA_W-1 -: DQ_W];

  assign sample_d = sample_pipe_q[SAMPLE_DELAY-1];
  // The final capture has no setup after it and shifts on its own.
  assign shift    = setup_d_q || (sample_d && stop_i);

  // ==============================
  // Next lane bits and buffer
  // ==============================

  always_comb begin
    txd_next = '0;
    case (proto_eff)
      PROTO_SINGLE: txd_next[0]   = tx_top[DQ_W-1];
      PROTO_DUAL:   txd_next[1:0] = tx_top[DQ_W-1 -: 2];
      PROTO_QUAD:   txd_next      = tx_top;
      default:      txd_next      = '0;
    endcase
  end

  // Sampled lanes land in the low bits and move up on the following shift.
  always_comb begin
    buf_next = buf_q;
    if (fire_xfr) begin
      buf_next = tx_byte;
    end else begin
      case (proto_q)
        PROTO_SINGLE: begin
          if (shift) buf_next[DATA_W-1:1] = buf_q[DATA_W-2:0];
          if (sample_d) buf_next[0] = dq_i[1];
        end
        PROTO_DUAL: begin
          if (shift) buf_next[DATA_W-1:2] = buf_q[DATA_W-3:0];
          if (sample_d) buf_next[1:0] = dq_i[1:0];
        end
        PROTO_QUAD: begin
          if (shift) buf_next[DATA_W-1:DQ_W] = buf_q[DATA_W-DQ_W-1:0];
          if (sample_d) buf_next[DQ_W-1:0] = dq_i;
        end
        default: buf_next = buf_q;
      endcase
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      proto_q       <= PROTO_SINGLE;
      endian_q      <= 1'b0;
      buf_q         <= '0;
      txd_q         <= '0;
      setup_d_q     <= 1'b0;
      sample_pipe_q <= '0;
    end else begin
      if (load_fmt) begin
        proto_q  <= fmt_proto_i;
        endian_q <= fmt_endian_i;
      end
      buf_q <= buf_next;
      if (setup_i) begin
        txd_q <= txd_next;
      end
      setup_d_q     <= setup_i;
      sample_pipe_q <= {sample_pipe_q[SAMPLE_DELAY-2:0], sample_i};
    end
  end

  assign proto_o   = proto_q;
  assign dq_o      = txd_q;
  assign rx_data_o = endian_q ? bit_reverse(buf_q) : buf_q;

  // The far end samples while the lane bits hold steady.
  a_txd_steady: assert property (@(posedge clock) disable iff (reset)
    sample_i |=> $stable(txd_q))
    else $error("Lane output register changed on a sampling strobe");

endmodule

`default_nettype wire

//--- rtl/qspi_op_sequencer.sv
// Operation sequencer of the quad-SPI physical layer.
// Accepts operations, tracks when the received byte is complete and drives
// the output enables of the data lanes from the protocol and direction.

`timescale 1ns/1ps
`default_nettype none

module qspi_op_sequencer
  import qspi_phy_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  input  wire              op_valid_i,
  input  var  op_fn_e      op_fn_i,
  input  wire              op_stb_i,
  input  wire [CNT_W-1:0]  op_cnt_i,
  input  wire              fmt_iodir_i,  // High when the lanes drive data out.
  input  wire              stop_i,
  input  wire              last_i,
  input  var  proto_e      proto_i,
  output logic             op_fire_o,
  output logic             op_ready_o,
  output logic             rx_valid_o,
  output logic [DQ_W-1:0]  dq_oe_o
);

  logic [SAMPLE_DELAY-1:0] last_pipe_q;
  logic                    last_d;
  logic                    done_q;
  logic                    iodir_q;
  logic                    wide_out;
  logic                    quad_out;

  assign last_d     = last_pipe_q[SAMPLE_DELAY-1];
  assign op_ready_o = done_q && stop_i;
  assign op_fire_o  = op_valid_i && op_ready_o;
  assign rx_valid_o = done_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      last_pipe_q <= '0;
      done_q      <= 1'b1;
      iodir_q     <= 1'b0;
    end else begin
      last_pipe_q <= {last_pipe_q[SAMPLE_DELAY-2:0], last_i};
      if (op_fire_o && (op_fn_i == FN_TRANSFER)) begin
        done_q <= (op_cnt_i == '0);  // An empty transfer is done at once.
      end else if (last_d) begin
        done_q <= 1'b1;
      end
      if (op_fire_o && op_stb_i) begin
        iodir_q <= fmt_iodir_i;
      end
    end
  end

  // ==============================
  // Lane enables
  // ==============================

  // Single mode always sends on lane 0 and listens on lane 1.
  assign wide_out = iodir_q && ((proto_i == PROTO_DUAL) || (proto_i == PROTO_QUAD));
  assign quad_out = iodir_q && (proto_i == PROTO_QUAD);

  assign dq_oe_o = {quad_out, quad_out, wide_out, (proto_i == PROTO_SINGLE) || wide_out};

  // A counted operation keeps the scheduler busy, which blocks the next fire.
  a_fire_busy: assert property (@(posedge clock) disable iff (reset)
    op_fire_o && (op_cnt_i != '0) |=> !stop_i && !op_fire_o)
    else $error("Scheduler did not start on an accepted operation");

endmodule

`default_nettype wire

//--- rtl/qspi_phy.sv
// Top level of the quad-SPI physical layer.
// Connects the clock scheduler, the shift buffer and the operation sequencer
// to the operation port, the control settings and the pads. One operation
// runs at a time and the caller waits for op_ready_o.

`timescale 1ns/1ps
`default_nettype none

module qspi_phy
  import qspi_phy_pkg::*;
(
  input  wire               clock,
  input  wire               reset,
  // Operation port.
  input  wire               op_valid_i,
  input  var  op_fn_e       op_fn_i,
  input  wire               op_stb_i,
  input  wire [CNT_W-1:0]   op_cnt_i,
  input  wire [DATA_W-1:0]  op_data_i,
  output logic              op_ready_o,
  // Control settings, latched on a strobe.
  input  wire [DIV_W-1:0]   sck_div_i,
  input  wire               sck_pol_i,
  input  wire               sck_pha_i,
  input  var  proto_e       fmt_proto_i,
  input  wire               fmt_endian_i,
  input  wire               fmt_iodir_i,
  // Received byte.
  output logic              rx_valid_o,
  output logic [DATA_W-1:0] rx_data_o,
  // Pads.
  output logic              sck_o,
  input  wire [DQ_W-1:0]    dq_i,
  output logic [DQ_W-1:0]   dq_o,
  output logic [DQ_W-1:0]   dq_oe_o
);

  logic   op_fire;
  logic   setup;
  logic   sample;
  logic   last;
  logic   stop;
  proto_e proto;

  qspi_sck_gen sck_gen_i (
    .clock     (clock),
    .reset     (reset),
    .op_fire_i (op_fire),
    .op_fn_i   (op_fn_i),
    .op_stb_i  (op_stb_i),
    .op_cnt_i  (op_cnt_i),
    .sck_div_i (sck_div_i),
    .sck_pol_i (sck_pol_i),
    .sck_pha_i (sck_pha_i),
    .sck_o     (sck_o),
    .setup_o   (setup),
    .sample_o  (sample),
    .last_o    (last),
    .stop_o    (stop)
  );

  qspi_shift_buffer shift_buffer_i (
    .clock        (clock),
    .reset        (reset),
    .op_fire_i    (op_fire),
    .op_fn_i      (op_fn_i),
    .op_stb_i     (op_stb_i),
    .op_data_i    (op_data_i),
    .fmt_proto_i  (fmt_proto_i),
    .fmt_endian_i (fmt_endian_i),
    .setup_i      (setup),
    .sample_i     (sample),
    .stop_i       (stop),
    .dq_i         (dq_i),
    .proto_o      (proto),
    .dq_o         (dq_o),
    .rx_data_o    (rx_data_o)
  );

  qspi_op_sequencer op_sequencer_i (
    .clock       (clock),
    .reset       (reset),
    .op_valid_i  (op_valid_i),
    .op_fn_i     (op_fn_i),
    .op_stb_i    (op_stb_i),
    .op_cnt_i    (op_cnt_i),
    .fmt_iodir_i (fmt_iodir_i),
    .stop_i      (stop),
    .last_i      (last),
    .proto_i     (proto),
    .op_fire_o   (op_fire),
    .op_ready_o  (op_ready_o),
    .rx_valid_o  (rx_valid_o),
    .dq_oe_o     (dq_oe_o)
  );

endmodule

`default_nettype wire

//--- testbench/qspi_bus_model.sv
// Flash-side model for the quad-SPI physical layer testbench.
// Drives a held nibble on the input lanes, counts serial clock toggles and
// records the output lanes on every sampling edge of the serial clock.

`timescale 1ns/1ps
`default_nettype none

module qspi_bus_model
  import qspi_phy_pkg::*;
(
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    sck_i,
  input  wire                    sample_level_i,  // Level of sck after a sampling edge.
  input  wire [DQ_W-1:0]         nibble_i,
  input  wire [DQ_W-1:0]         data_i,          // Output lanes of the DUT.
  output logic [DQ_W-1:0]        data_o,          // Input lanes of the DUT.
  output logic [DATA_W*DQ_W-1:0] capture_o,       // Newest capture sits in the low lanes.
  output int                     captures_o,
  output int                     toggles_o
);

  logic sck_q;

  assign data_o = nibble_i;

  // The serial clock only moves on system clock edges, so comparing its level
  // at each edge sees every transition.
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      sck_q      <= 1'b0;
      capture_o  <= '0;
      captures_o <= 0;
      toggles_o  <= 0;
    end else begin
      sck_q <= sck_i;
      if (sck_i != sck_q) begin
        toggles_o <= toggles_o + 1;
        if (sck_i == sample_level_i) begin
          capture_o  <= {capture_o[DATA_W*DQ_W-DQ_W-1:0], data_i};
          captures_o <= captures_o + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/qspi_phy_tb.sv
// Testbench for the quad-SPI physical layer.
// Runs seeded random rounds of a settings operation, a timing operation and
// a byte transfer against a flash-side model, and checks every result
// against the layer's rules. Ends with an error count and a verdict line.

`timescale 1ns/1ps
`default_nettype none

module qspi_phy_tb
  import qspi_phy_pkg::*;
();

  localparam int SEED         = 5;
  localparam int NUM_ROUNDS   = 60;
  localparam int CLK_PERIOD   = 4;
  localparam int ROUND_CYCLES = 300;  // Transfer of cnt 8 at div 7 plus a timing op.

  logic                   clock;
  logic                   reset;
  logic                   op_valid;
  op_fn_e                 op_fn;
  logic                   op_stb;
  logic [CNT_W-1:0]       op_cnt;
  logic [DATA_W-1:0]      op_data;
  logic                   op_ready;
  logic [DIV_W-1:0]       sck_div;
  logic                   sck_pol;
  logic                   sck_pha;
  proto_e                 fmt_proto;
  logic                   fmt_endian;
  logic                   fmt_iodir;
  logic                   rx_valid;
  logic [DATA_W-1:0]      rx_data;
  logic                   sck;
  logic [DQ_W-1:0]        dq_in;
  logic [DQ_W-1:0]        dq_out;
  logic [DQ_W-1:0]        dq_oe;
  logic [DQ_W-1:0]        nibble;
  logic                   sample_level;
  logic [DATA_W*DQ_W-1:0] capture;
  int                     captures;
  int                     toggles;
  int                     errors;

  // Phase 0 samples on the edge leaving idle, phase 1 on the edge returning to it.
  assign sample_level = sck_pha ? sck_pol : !sck_pol;

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  qspi_phy qspi_phy_i (
    .clock        (clock),
    .reset        (reset),
    .op_valid_i   (op_valid),
    .op_fn_i      (op_fn),
    .op_stb_i     (op_stb),
    .op_cnt_i     (op_cnt),
    .op_data_i    (op_data),
    .op_ready_o   (op_ready),
    .sck_div_i    (sck_div),
    .sck_pol_i    (sck_pol),
    .sck_pha_i    (sck_pha),
    .fmt_proto_i  (fmt_proto),
    .fmt_endian_i (fmt_endian),
    .fmt_iodir_i  (fmt_iodir),
    .rx_valid_o   (rx_valid),
    .rx_data_o    (rx_data),
    .sck_o        (sck),
    .dq_i         (dq_in),
    .dq_o         (dq_out),
    .dq_oe_o      (dq_oe)
  );

  qspi_bus_model bus_model_i (
    .clock          (clock),
    .reset          (reset),
    .sck_i          (sck),
    .sample_level_i (sample_level),
    .nibble_i       (nibble),
    .data_i         (dq_out),
    .data_o         (dq_in),
    .capture_o      (capture),
    .captures_o     (captures),
    .toggles_o      (toggles)
  );

  // ==============================
  // Reference rules
  // ==============================

  function automatic logic [DATA_W-1:0] flip_bits(logic [DATA_W-1:0] value);
    logic [DATA_W-1:0] result;
    for (int i = 0; i < DATA_W; i++) begin
      result[DATA_W-1-i] = value[i];
    end
    return result;
  endfunction

  function automatic int lane_count(proto_e proto);
    case (proto)
      PROTO_DUAL: return 2;
      PROTO_QUAD: return 4;
      default:    return 1;
    endcase
  endfunction

  function automatic logic [DQ_W-1:0] expected_oe(proto_e proto, logic iodir);
    case (proto)
      PROTO_SINGLE: return 4'b0001;
      PROTO_DUAL:   return iodir ? 4'b0011 : 4'b0000;
      default:      return iodir ? 4'b1111 : 4'b0000;
    endcase
  endfunction

  // A held nibble fills the byte with the lanes that the format reads.
  function automatic logic [DATA_W-1:0] repeat_lanes(proto_e proto, logic [DQ_W-1:0] nib);
    case (proto)
      PROTO_DUAL: return {4{nib[1:0]}};
      PROTO_QUAD: return {2{nib}};
      default:    return {8{nib[1]}};
    endcase
  endfunction

  // The first capture carries the top bits, with the highest lane first.
  function automatic logic [DATA_W-1:0] rebuild_byte(proto_e proto,
                                                     logic [DATA_W*DQ_W-1:0] cap);
    logic [DATA_W-1:0] result;
    result = '0;
    for (int i = 0; i < DATA_W; i++) begin
      case (proto)
        PROTO_SINGLE: result[i] = cap[DQ_W*i];
        PROTO_DUAL:   result[i] = cap[DQ_W*(i/2) + i%2];
        default:      result[i] = cap[i];
      endcase
    end
    return result;
  endfunction

  // ==============================
  // Operation driving and reporting
  // ==============================

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_event(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic send_op(input op_fn_e fn, input logic stb, input logic [CNT_W-1:0] cnt,
                         input logic [DATA_W-1:0] data);
    op_valid <= 1'b1;
    op_fn    <= fn;
    op_stb   <= stb;
    op_cnt   <= cnt;
    op_data  <= data;
    @(posedge clock);
    while (!op_ready) begin
      @(posedge clock);
    end
    op_valid <= 1'b0;  // Accepted at this edge.
    op_stb   <= 1'b0;
    @(posedge clock);
    while (!op_ready) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);  // The bus model needs an edge to see the last toggle.
  endtask

  initial begin
    proto_e            proto;
    logic              endian;
    logic              iodir;
    logic [DQ_W-1:0]   nib;
    logic [DATA_W-1:0] tx_byte;
    logic [DATA_W-1:0] exp_rx;
    logic [DATA_W-1:0] sent;
    logic [DATA_W-1:0] rx_before;
    int                cnt;
    int                toggles_before;
    int                captures_before;
    void'($urandom(SEED));
    errors     = 0;
    reset      = 1'b1;
    op_valid   = 1'b0;
    op_fn      = FN_TRANSFER;
    op_stb     = 1'b0;
    op_cnt     = '0;
    op_data    = '0;
    sck_div    = '0;
    sck_pol    = 1'b0;
    sck_pha    = 1'b0;
    fmt_proto  = PROTO_SINGLE;
    fmt_endian = 1'b0;
    fmt_iodir  = 1'b0;
    nibble     = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    if (op_ready !== 1'b1) report_mismatch("op_ready_o", 32'(op_ready), 32'd1);
    if (rx_valid !== 1'b1) report_mismatch("rx_valid_o", 32'(rx_valid), 32'd1);
    if (sck !== 1'b0) report_mismatch("sck_o", 32'(sck), 32'd0);
    if (dq_oe !== 4'b0001) report_mismatch("dq_oe_o", 32'(dq_oe), 32'h1);

    for (int round = 0; round < NUM_ROUNDS; round++) begin
      proto      = proto_e'(2'($urandom_range(2, 0)));
      endian     = 1'($urandom_range(1, 0));
      iodir      = 1'($urandom_range(1, 0));
      sck_div    <= DIV_W'($urandom_range(7, 0));
      sck_pol    <= 1'($urandom_range(1, 0));
      sck_pha    <= 1'($urandom_range(1, 0));
      fmt_proto  <= proto;
      fmt_endian <= endian;
      fmt_iodir  <= iodir;
      send_op(FN_TIMING, 1'b1, '0, '0);  // An empty timing op takes the new settings.
      if (dq_oe !== expected_oe(proto, iodir)) begin
        report_mismatch("dq_oe_o", 32'(dq_oe), 32'(expected_oe(proto, iodir)));
      end

      rx_before      = rx_data;
      toggles_before = toggles;
      cnt            = $urandom_range(4, 1);
      send_op(FN_TIMING, 1'b0, CNT_W'(cnt), '0);
      if (toggles != toggles_before) report_event("sck_o toggled during a timing operation");
      if (rx_data !== rx_before) report_mismatch("rx_data_o", 32'(rx_data), 32'(rx_before));
      if (op_ready !== 1'b1) report_mismatch("op_ready_o", 32'(op_ready), 32'd1);

      cnt             = DATA_W / lane_count(proto);
      tx_byte         = DATA_W'($urandom_range(255, 0));
      nib             = DQ_W'($urandom_range(15, 0));
      nibble          <= nib;
      toggles_before  = toggles;
      captures_before = captures;
      send_op(FN_TRANSFER, 1'($urandom_range(1, 0)), CNT_W'(cnt), tx_byte);

      exp_rx = repeat_lanes(proto, nib);
      if (endian) exp_rx = flip_bits(exp_rx);
      sent = rebuild_byte(proto, capture);
      if (endian) sent = flip_bits(sent);
      if (rx_valid !== 1'b1) report_mismatch("rx_valid_o", 32'(rx_valid), 32'd1);
      if (rx_data !== exp_rx) report_mismatch("rx_data_o", 32'(rx_data), 32'(exp_rx));
      if (captures - captures_before != cnt) begin
        report_event("Bus model saw a wrong number of sampling edges in a transfer");
      end
      if (sent !== tx_byte) report_mismatch("dq_o", 32'(sent), 32'(tx_byte));
      if (toggles - toggles_before != 2 * cnt) begin
        report_mismatch("sck_o toggles", toggles - toggles_before, 2 * cnt);
      end
    end

    $display("Rounds run: %0d, errors: %0d", NUM_ROUNDS, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((NUM_ROUNDS * ROUND_CYCLES + 16) * CLK_PERIOD);
    $display("Watchdog expired at %0t ns before the rounds finished", $time);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- qspi_phy.f
rtl/qspi_phy_pkg.sv
rtl/qspi_sck_gen.sv
rtl/qspi_shift_buffer.sv
rtl/qspi_op_sequencer.sv
rtl/qspi_phy.sv
testbench/qspi_bus_model.sv
testbench/qspi_phy_tb.sv

//--- Makefile
# Verilator flow for the quad-SPI physical layer.
# Any variable can be overridden on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= qspi_phy.f
TB_TOP     ?= qspi_phy_tb
RTL_TOP    ?= qspi_phy
OBJ_DIR    ?= obj_dir
RTL_FILES  ?= rtl/qspi_phy_pkg.sv rtl/qspi_sck_gen.sv rtl/qspi_shift_buffer.sv \
              rtl/qspi_op_sequencer.sv rtl/qspi_phy.sv
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
PASS_TEXT  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
